// ==== common/rv32i_cfg.svh ====
`ifndef RV32I_CFG_SVH
`define RV32I_CFG_SVH

// data width of the core.
`define RV_XLEN  32

// number of architectural integer registers, x0 included.
`define RV_NREGS 32

// addi x0, x0, 0 is what an idle pipe carries.
`define RV_NOP   32'h00000013

`endif

// ==== common/rv32i_pkg.sv ====
`include "rv32i_cfg.svh"

package rv32i_pkg;

    typedef logic [`RV_XLEN-1:0]          word_t;
    typedef logic [$clog2(`RV_NREGS)-1:0] reg_idx_t;

    // major opcodes that the core accepts. anything else is a bubble.
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    // follows funct3, with sub and sra taking the two slots left by slt and sltu.
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_op_t;

    // branch funct3 values. slt and sltu reuse blt and bltu.
    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_op_t;

    typedef enum logic {
        a_sel_rs1 = 1'b0,
        a_sel_pc  = 1'b1
    } alu_a_sel_t;

    typedef enum logic [2:0] {
        b_sel_rs2    = 3'd0,
        b_sel_u_imm  = 3'd1,
        b_sel_i_imm  = 3'd2,
        b_sel_s_imm  = 3'd3,
        b_sel_const4 = 3'd4
    } alu_b_sel_t;

    typedef enum logic {
        cmp_b_rs2   = 1'b0,
        cmp_b_i_imm = 1'b1
    } cmp_b_sel_t;

endpackage

// ==== decode/regfile.sv ====
`timescale 1ns/1ps
`include "rv32i_cfg.svh"

module regfile (
    input  logic                clk,
    input  logic                rst,
    input  rv32i_pkg::reg_idx_t rs1_idx,
    input  rv32i_pkg::reg_idx_t rs2_idx,
    output rv32i_pkg::word_t    rs1_v,
    output rv32i_pkg::word_t    rs2_v,
    input  logic                wb_en,
    input  rv32i_pkg::reg_idx_t wb_rd,
    input  rv32i_pkg::word_t    wb_data
);
    import rv32i_pkg::*;

    // x0 has no storage behind it.
    word_t regs [1:`RV_NREGS-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && (wb_rd != '0)) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // reads see the array before the edge, so a same-cycle write is not bypassed.
    always_comb begin
        rs1_v = (rs1_idx == '0) ? '0 : regs[rs1_idx];
        rs2_v = (rs2_idx == '0) ? '0 : regs[rs2_idx];
    end

endmodule

// ==== decode/decode_stage.sv ====
`timescale 1ns/1ps
`include "rv32i_cfg.svh"

module decode_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  rv32i_pkg::word_t      in_inst,
    input  rv32i_pkg::word_t      in_pc,
    output rv32i_pkg::reg_idx_t   rs1_idx,
    output rv32i_pkg::reg_idx_t   rs2_idx,
    input  rv32i_pkg::word_t      rs1_v,
    input  rv32i_pkg::word_t      rs2_v,
    output logic                  id_valid,
    output rv32i_pkg::word_t      id_inst,
    output rv32i_pkg::word_t      id_pc,
    output rv32i_pkg::reg_idx_t   id_rd,
    output rv32i_pkg::word_t      id_rs1_v,
    output rv32i_pkg::word_t      id_rs2_v,
    output rv32i_pkg::word_t      id_u_imm,
    output rv32i_pkg::word_t      id_i_imm,
    output rv32i_pkg::word_t      id_s_imm,
    output rv32i_pkg::alu_a_sel_t id_alu_a_sel,
    output rv32i_pkg::alu_b_sel_t id_alu_b_sel,
    output rv32i_pkg::cmp_b_sel_t id_cmp_b_sel,
    output rv32i_pkg::alu_op_t    id_aluop,
    output rv32i_pkg::cmp_op_t    id_cmpop
);
    import rv32i_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       op_ok;
    alu_op_t    arith_op;
    cmp_op_t    slt_op;
    alu_a_sel_t alu_a_sel;
    alu_b_sel_t alu_b_sel;
    cmp_b_sel_t cmp_b_sel;
    alu_op_t    aluop;
    cmp_op_t    cmpop;

    assign opcode = opcode_t'(in_inst[6:0]);
    assign funct3 = in_inst[14:12];
    assign funct7 = in_inst[31:25];

    // lui has immediate bits in the rs1 field, so it reads x0 and adds.
    assign rs1_idx = (opcode == op_lui) ? '0 : in_inst[19:15];
    assign rs2_idx = in_inst[24:20];

    // shared by op and op-imm. addi never becomes sub.
    always_comb begin
        unique case (funct3)
            3'b000:         arith_op = (opcode == op_reg && funct7[5]) ? alu_sub : alu_add;
            3'b101:         arith_op = funct7[5] ? alu_sra : alu_srl;
            3'b010, 3'b011: arith_op = alu_add;
            default:        arith_op = alu_op_t'(funct3);
        endcase
        slt_op = (funct3 == 3'b011) ? cmp_bltu : cmp_blt;
    end

    always_comb begin
        op_ok     = 1'b1;
        alu_a_sel = a_sel_rs1;
        alu_b_sel = b_sel_rs2;
        cmp_b_sel = cmp_b_rs2;
        aluop     = alu_add;
        cmpop     = cmp_beq;
        case (opcode)
            op_lui:   alu_b_sel = b_sel_u_imm;
            op_auipc: begin
                alu_a_sel = a_sel_pc;
                alu_b_sel = b_sel_u_imm;
            end
            op_jal, op_jalr: begin
                alu_a_sel = a_sel_pc;
                alu_b_sel = b_sel_const4;
            end
            op_br:    cmpop = cmp_op_t'(funct3);
            op_load:  alu_b_sel = b_sel_i_imm;
            op_store: alu_b_sel = b_sel_s_imm;
            op_imm: begin
                alu_b_sel = b_sel_i_imm;
                cmp_b_sel = cmp_b_i_imm;
                aluop     = arith_op;
                cmpop     = slt_op;
            end
            op_reg: begin
                aluop = arith_op;
                cmpop = slt_op;
            end
            default:  op_ok = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            id_valid <= 1'b0;
        end else begin
            id_valid <= in_valid && op_ok;
        end
    end

    always_ff @(posedge clk) begin
        id_inst      <= in_inst;
        id_pc        <= in_pc;
        id_rd        <= in_inst[11:7];
        id_rs1_v     <= rs1_v;
        id_rs2_v     <= rs2_v;
        id_u_imm     <= {in_inst[31:12], 12'h000};
        id_i_imm     <= {{(`RV_XLEN-11){in_inst[31]}}, in_inst[30:20]};
        id_s_imm     <= {{(`RV_XLEN-11){in_inst[31]}}, in_inst[30:25], in_inst[11:7]};
        id_alu_a_sel <= alu_a_sel;
        id_alu_b_sel <= alu_b_sel;
        id_cmp_b_sel <= cmp_b_sel;
        id_aluop     <= aluop;
        id_cmpop     <= cmpop;
    end

    id_b_sel_defined: assert property (@(posedge clk) disable iff (rst)
        id_valid |-> id_alu_b_sel inside {b_sel_rs2, b_sel_u_imm, b_sel_i_imm,
                                          b_sel_s_imm, b_sel_const4})
        else $error("id_alu_b_sel %0h is not a defined select", id_alu_b_sel);

endmodule

// ==== execute/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  rv32i_pkg::alu_op_t aluop,
    input  rv32i_pkg::word_t   a,
    input  rv32i_pkg::word_t   b,
    output rv32i_pkg::word_t   aluout
);
    import rv32i_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        unique case (aluop)
            alu_add: aluout = a + b;
            alu_sll: aluout = a << shamt;
            alu_sra: aluout = word_t'($signed(a) >>> shamt);
            alu_sub: aluout = a - b;
            alu_xor: aluout = a ^ b;
            alu_srl: aluout = a >> shamt;
            alu_or:  aluout = a | b;
            alu_and: aluout = a & b;
            default: aluout = 'x;
        endcase
    end

endmodule

// ==== execute/cmp.sv ====
`timescale 1ns/1ps

module cmp (
    input  rv32i_pkg::cmp_op_t cmpop,
    input  rv32i_pkg::word_t   a,
    input  rv32i_pkg::word_t   b,
    output logic               br_en
);
    import rv32i_pkg::*;

    always_comb begin
        unique case (cmpop)
            cmp_beq:  br_en = (a == b);
            cmp_bne:  br_en = (a != b);
            cmp_blt:  br_en = ($signed(a) < $signed(b));
            cmp_bge:  br_en = ($signed(a) >= $signed(b));
            cmp_bltu: br_en = (a < b);
            cmp_bgeu: br_en = (a >= b);
            // the two reserved branch encodings never take.
            default:  br_en = 1'b0;
        endcase
    end

endmodule

// ==== execute/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  id_valid,
    input  rv32i_pkg::word_t      id_inst,
    input  rv32i_pkg::word_t      id_pc,
    input  rv32i_pkg::reg_idx_t   id_rd,
    input  rv32i_pkg::word_t      id_rs1_v,
    input  rv32i_pkg::word_t      id_rs2_v,
    input  rv32i_pkg::word_t      id_u_imm,
    input  rv32i_pkg::word_t      id_i_imm,
    input  rv32i_pkg::word_t      id_s_imm,
    input  rv32i_pkg::alu_a_sel_t id_alu_a_sel,
    input  rv32i_pkg::alu_b_sel_t id_alu_b_sel,
    input  rv32i_pkg::cmp_b_sel_t id_cmp_b_sel,
    input  rv32i_pkg::alu_op_t    id_aluop,
    input  rv32i_pkg::cmp_op_t    id_cmpop,
    output logic                  ex_valid,
    output rv32i_pkg::word_t      ex_inst,
    output rv32i_pkg::word_t      ex_pc,
    output rv32i_pkg::reg_idx_t   ex_rd,
    output rv32i_pkg::word_t      ex_alu_out,
    output logic                  ex_br_en,
    output rv32i_pkg::word_t      ex_rs2_v
);
    import rv32i_pkg::*;

    word_t alu_a;
    word_t alu_b;
    word_t cmp_b;
    word_t alu_out;
    logic  br_en;

    always_comb begin
        unique case (id_alu_a_sel)
            a_sel_rs1: alu_a = id_rs1_v;
            a_sel_pc:  alu_a = id_pc;
            default:   alu_a = 'x;
        endcase
        unique case (id_alu_b_sel)
            b_sel_rs2:    alu_b = id_rs2_v;
            b_sel_u_imm:  alu_b = id_u_imm;
            b_sel_i_imm:  alu_b = id_i_imm;
            b_sel_s_imm:  alu_b = id_s_imm;
            b_sel_const4: alu_b = word_t'(4);
            default:      alu_b = 'x;
        endcase
        unique case (id_cmp_b_sel)
            cmp_b_rs2:   cmp_b = id_rs2_v;
            cmp_b_i_imm: cmp_b = id_i_imm;
            default:     cmp_b = 'x;
        endcase
    end

    alu u_alu (.aluop(id_aluop), .a(alu_a), .b(alu_b), .aluout(alu_out));
    cmp u_cmp (.cmpop(id_cmpop), .a(id_rs1_v), .b(cmp_b), .br_en(br_en));

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= id_valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_inst    <= id_inst;
        ex_pc      <= id_pc;
        ex_rd      <= id_rd;
        ex_alu_out <= alu_out;
        ex_br_en   <= br_en;
        ex_rs2_v   <= id_rs2_v;
    end

    // an unknown here means decode handed over a select that no mux arm covers.
    ex_alu_out_known: assert property (@(posedge clk) disable iff (rst)
        (ex_valid && ex_inst[6:0] != op_br) |-> !$isunknown(ex_alu_out))
        else $error("ex_alu_out has unknown bits for inst %08h", ex_inst);

endmodule

// ==== design/exec_core_top.sv ====
`timescale 1ns/1ps

module exec_core_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  rv32i_pkg::word_t    in_inst,
    input  rv32i_pkg::word_t    in_pc,
    input  logic                wb_en,
    input  rv32i_pkg::reg_idx_t wb_rd,
    input  rv32i_pkg::word_t    wb_data,
    output logic                ex_valid,
    output rv32i_pkg::word_t    ex_inst,
    output rv32i_pkg::word_t    ex_pc,
    output rv32i_pkg::reg_idx_t ex_rd,
    output rv32i_pkg::word_t    ex_alu_out,
    output logic                ex_br_en,
    output rv32i_pkg::word_t    ex_rs2_v
);
    import rv32i_pkg::*;

    reg_idx_t   rs1_idx, rs2_idx;
    word_t      rs1_v, rs2_v;
    logic       id_valid;
    word_t      id_inst, id_pc, id_rs1_v, id_rs2_v;
    reg_idx_t   id_rd;
    word_t      id_u_imm, id_i_imm, id_s_imm;
    alu_a_sel_t id_alu_a_sel;
    alu_b_sel_t id_alu_b_sel;
    cmp_b_sel_t id_cmp_b_sel;
    alu_op_t    id_aluop;
    cmp_op_t    id_cmpop;

    decode_stage u_decode_stage (.*);

    regfile u_regfile (.*);

    execute_stage u_execute_stage (.*);

endmodule

// ==== test/tb_exec_core.sv ====
`timescale 1ns/1ps
`include "rv32i_cfg.svh"

module tb_exec_core;
    import rv32i_pkg::*;

    typedef struct packed {
        int       due;
        logic     valid;
        word_t    inst;
        word_t    pc;
        reg_idx_t rd;
        logic     chk_alu;
        word_t    alu_out;
        logic     chk_br;
        logic     br_en;
        logic     chk_rs2;
        word_t    rs2_v;
    } exp_t;

    logic     clk;
    logic     rst;
    logic     in_valid;
    word_t    in_inst;
    word_t    in_pc;
    logic     wb_en;
    reg_idx_t wb_rd;
    word_t    wb_data;
    logic     ex_valid;
    word_t    ex_inst;
    word_t    ex_pc;
    reg_idx_t ex_rd;
    word_t    ex_alu_out;
    logic     ex_br_en;
    word_t    ex_rs2_v;

    word_t    model_regs [`RV_NREGS];
    exp_t     exp_q [$];
    exp_t     exp_now;
    logic     check_on = 1'b0;
    int       cycle = 0;
    int       n_issued = 0;
    word_t    pc = 32'h0000_1000;

    exec_core_top u_exec_core_top (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic stop_on_mismatch(string name, word_t got, word_t want);
        $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, want);
        abort_run();
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle > n_issued * 4 + 200) begin
            $display("timeout: the pipe did not drain after %0d cycles", cycle);
            abort_run();
        end
    end

    // after each edge the ex_ outputs hold the instruction driven two edges before,
    // or nothing if no instruction is due.
    always @(posedge clk) begin
        #2;
        check_on = 1'b1;
        if (exp_q.size() != 0 && exp_q[0].due == cycle) begin
            exp_now = exp_q.pop_front();
        end else begin
            exp_now = '0;
        end
    end

    valid_matches: assert property (@(posedge clk) check_on |-> ex_valid == exp_now.valid)
        else stop_on_mismatch("ex_valid", $sampled(ex_valid), $sampled(exp_now.valid));
    inst_matches: assert property (@(posedge clk)
        check_on && exp_now.valid |-> ex_inst == exp_now.inst)
        else stop_on_mismatch("ex_inst", $sampled(ex_inst), $sampled(exp_now.inst));
    pc_matches: assert property (@(posedge clk)
        check_on && exp_now.valid |-> ex_pc == exp_now.pc)
        else stop_on_mismatch("ex_pc", $sampled(ex_pc), $sampled(exp_now.pc));
    rd_matches: assert property (@(posedge clk)
        check_on && exp_now.valid |-> ex_rd == exp_now.rd)
        else stop_on_mismatch("ex_rd", $sampled(ex_rd), $sampled(exp_now.rd));
    alu_matches: assert property (@(posedge clk)
        check_on && exp_now.valid && exp_now.chk_alu |-> ex_alu_out == exp_now.alu_out)
        else stop_on_mismatch("ex_alu_out", $sampled(ex_alu_out), $sampled(exp_now.alu_out));
    br_matches: assert property (@(posedge clk)
        check_on && exp_now.valid && exp_now.chk_br |-> ex_br_en == exp_now.br_en)
        else stop_on_mismatch("ex_br_en", $sampled(ex_br_en), $sampled(exp_now.br_en));
    rs2_matches: assert property (@(posedge clk)
        check_on && exp_now.valid && exp_now.chk_rs2 |-> ex_rs2_v == exp_now.rs2_v)
        else stop_on_mismatch("ex_rs2_v", $sampled(ex_rs2_v), $sampled(exp_now.rs2_v));

    function automatic word_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3, reg_idx_t rd, logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                    reg_idx_t rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    // branches share the store field layout. their offset bits are never looked at.
    function automatic word_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3, logic [6:0] op);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
    endfunction

    function automatic word_t enc_u(logic [19:0] imm, reg_idx_t rd, logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic exp_t model(word_t inst, word_t ipc);
        exp_t       e;
        logic [2:0] f3;
        word_t      a;
        word_t      b;
        word_t      opb;
        word_t      imm_i;
        e       = '0;
        f3      = inst[14:12];
        a       = model_regs[inst[19:15]];
        b       = model_regs[inst[24:20]];
        imm_i   = {{20{inst[31]}}, inst[31:20]};
        e.valid = 1'b1;
        e.inst  = inst;
        e.pc    = ipc;
        e.rd    = inst[11:7];
        e.rs2_v = b;
        e.chk_alu = 1'b1;
        case (inst[6:0])
            op_lui:          e.alu_out = {inst[31:12], 12'h000};
            op_auipc:        e.alu_out = ipc + {inst[31:12], 12'h000};
            op_jal, op_jalr: e.alu_out = ipc + 32'd4;
            op_load:         e.alu_out = a + imm_i;
            op_store: begin
                e.alu_out = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
                e.chk_rs2 = 1'b1;
            end
            op_br: begin
                e.chk_alu = 1'b0;
                e.chk_br  = 1'b1;
                case (f3)
                    3'b000:  e.br_en = (a == b);
                    3'b001:  e.br_en = (a != b);
                    3'b100:  e.br_en = ($signed(a) < $signed(b));
                    3'b101:  e.br_en = ($signed(a) >= $signed(b));
                    3'b110:  e.br_en = (a < b);
                    default: e.br_en = (a >= b);
                endcase
            end
            op_imm, op_reg: begin
                // bit 5 of the opcode tells register operands from immediates.
                opb = inst[5] ? b : imm_i;
                if (f3 == 3'b010 || f3 == 3'b011) begin
                    e.chk_alu = 1'b0;
                    e.chk_br  = 1'b1;
                    e.br_en   = (f3 == 3'b010) ? ($signed(a) < $signed(opb)) : (a < opb);
                end else begin
                    case (f3)
                        3'b000:  e.alu_out = (inst[5] && inst[30]) ? a - opb : a + opb;
                        3'b001:  e.alu_out = a << opb[4:0];
                        3'b100:  e.alu_out = a ^ opb;
                        3'b101:  e.alu_out = inst[30] ? word_t'($signed(a) >>> opb[4:0])
                                                      : a >> opb[4:0];
                        3'b110:  e.alu_out = a | opb;
                        default: e.alu_out = a & opb;
                    endcase
                end
            end
            default: e.valid = 1'b0;
        endcase
        return e;
    endfunction

    task automatic issue(word_t inst);
        exp_t e;
        e         = model(inst, pc);
        e.due     = cycle + 2;
        in_valid  = 1'b1;
        in_inst   = inst;
        in_pc     = pc;
        exp_q.push_back(e);
        n_issued++;
        pc        = pc + 32'd4;
        @(posedge clk);
        #1;
    endtask

    task automatic idle();
        in_valid = 1'b0;
        in_inst  = `RV_NOP;
        @(posedge clk);
        #1;
    endtask

    task automatic write_reg(reg_idx_t idx, word_t val);
        wb_en   = 1'b1;
        wb_rd   = idx;
        wb_data = val;
        if (idx != '0) begin
            model_regs[idx] = val;
        end
        @(posedge clk);
        #1;
        wb_en = 1'b0;
    endtask

    initial begin
        word_t imm;
        rst      = 1'b1;
        in_valid = 1'b0;
        in_inst  = `RV_NOP;
        in_pc    = '0;
        wb_en    = 1'b0;
        wb_rd    = '0;
        wb_data  = '0;
        for (int i = 0; i < `RV_NREGS; i++) begin
            model_regs[i] = '0;
        end
        void'($urandom(32'h77f9));
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // signed and unsigned edge values go in the low registers.
        write_reg(5'd1, 32'h8000_0000);
        write_reg(5'd2, 32'h7fff_ffff);
        write_reg(5'd3, 32'hffff_ffff);
        write_reg(5'd4, 32'h0000_0001);
        for (int i = 5; i < `RV_NREGS; i++) begin
            write_reg(reg_idx_t'(i), $urandom);
        end
        write_reg(5'd0, $urandom);
        repeat (2) idle();

        for (int f = 0; f < 8; f++) begin
            issue(enc_r(7'h00, 5'd2, 5'd1, f[2:0], 5'd6, op_reg));
            issue(enc_r(7'h00, 5'd12, 5'd11, f[2:0], 5'd7, op_reg));
        end
        issue(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd8, op_reg));
        issue(enc_r(7'h20, 5'd13, 5'd1, 3'b101, 5'd8, op_reg));
        issue(enc_r(7'h20, 5'd14, 5'd3, 3'b000, 5'd8, op_reg));

        for (int f = 0; f < 8; f++) begin
            imm = $urandom;
            if (f == 1 || f == 5) begin
                imm[11:5] = '0;
            end
            issue(enc_i(imm[11:0], 5'd15, f[2:0], 5'd9, op_imm));
            issue(enc_i(imm[11:0], 5'd1, f[2:0], 5'd9, op_imm));
        end
        issue(enc_i(12'h407, 5'd1, 3'b101, 5'd9, op_imm));
        issue(enc_i(12'h000, 5'd3, 3'b010, 5'd9, op_imm));
        issue(enc_i(12'hfff, 5'd3, 3'b011, 5'd9, op_imm));
        issue(enc_i(12'hfff, 5'd4, 3'b011, 5'd9, op_imm));
        issue(enc_i(12'h800, 5'd2, 3'b010, 5'd9, op_imm));

        imm = $urandom;
        issue(enc_u(imm[19:0], 5'd10, op_lui));
        issue(enc_u(imm[31:12], 5'd10, op_auipc));
        issue(enc_u(imm[19:0], 5'd1, op_jal));
        issue(enc_i(imm[11:0], 5'd16, 3'b000, 5'd1, op_jalr));

        for (int i = 0; i < 4; i++) begin
            imm = $urandom;
            issue(enc_i(imm[11:0], reg_idx_t'(17 + i), 3'b010, 5'd20, op_load));
            issue(enc_s(imm[23:12], reg_idx_t'(21 + i), reg_idx_t'(17 + i), 3'b010, op_store));
        end

        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) begin
                issue(enc_s(12'h010, 5'd2, 5'd1, f[2:0], op_br));
                issue(enc_s(12'h010, 5'd1, 5'd2, f[2:0], op_br));
                issue(enc_s(12'h010, 5'd4, 5'd3, f[2:0], op_br));
                issue(enc_s(12'h010, 5'd3, 5'd4, f[2:0], op_br));
                issue(enc_s(12'h010, 5'd3, 5'd3, f[2:0], op_br));
                issue(enc_s(12'h010, 5'd0, 5'd1, f[2:0], op_br));
            end
        end

        // x0 was written during the load and must still read zero.
        issue(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd10, op_reg));
        issue(enc_i(imm[11:0], 5'd0, 3'b000, 5'd11, op_imm));
        issue(enc_s(imm[11:0], 5'd0, 5'd5, 3'b010, op_store));

        idle();
        issue(enc_i(12'h000, 5'd0, 3'b000, 5'd0, 7'b0001111));
        issue(32'h0000_0073);
        issue(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd6, op_reg));
        repeat (2) idle();
        issue(enc_r(7'h00, 5'd4, 5'd3, 3'b000, 5'd6, op_reg));
        idle();

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+common
common/rv32i_pkg.sv
decode/regfile.sv
decode/decode_stage.sv
execute/alu.sv
execute/cmp.sv
execute/execute_stage.sv
design/exec_core_top.sv
test/tb_exec_core.sv
